// ==== dv/head_assertions.sv ====
module head_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                out_valid,
    input logic                out_ready,
    input head_pkg::act_t      out_data,
    input head_pkg::out_idx_t  out_idx,
    input logic                done,
    input logic                host_wr_valid,
    input logic                host_wr_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled score holds until taken
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_idx))
        else $error("stalled score changed or dropped");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    a_host_ready: assert property (@(posedge clk) disable iff (!rst_n)
        host_wr_ready |-> host_wr_valid)
        else $error("host ready without a host request");

endmodule

// ==== dv/head_stimulus.txt ====
# per run: config (gap_mul gap_shift fc_mul fc_shift), 16 channel lines of 16 pixels,
# 10 weight lines of 16 inputs, one line of 10 biases, one line of 10 expected scores
# run 1
0001 04 0003 04
f9 f7 f9 f7 f9 f7 f9 f7 f9 f7 f9 f7 f9 f7 f9 f7
fa f8 fa f8 fa f8 fa f8 fa f8 fa f8 fa f8 fa f8
fb f9 fb f9 fb f9 fb f9 fb f9 fb f9 fb f9 fb f9
fc fa fc fa fc fa fc fa fc fa fc fa fc fa fc fa
fd fb fd fb fd fb fd fb fd fb fd fb fd fb fd fb
fe fc fe fc fe fc fe fc fe fc fe fc fe fc fe fc
ff fd ff fd ff fd ff fd ff fd ff fd ff fd ff fd
00 fe 00 fe 00 fe 00 fe 00 fe 00 fe 00 fe 00 fe
01 ff 01 ff 01 ff 01 ff 01 ff 01 ff 01 ff 01 ff
02 00 02 00 02 00 02 00 02 00 02 00 02 00 02 00
03 01 03 01 03 01 03 01 03 01 03 01 03 01 03 01
04 02 04 02 04 02 04 02 04 02 04 02 04 02 04 02
05 03 05 03 05 03 05 03 05 03 05 03 05 03 05 03
06 04 06 04 06 04 06 04 06 04 06 04 06 04 06 04
07 05 07 05 07 05 07 05 07 05 07 05 07 05 07 05
08 06 08 06 08 06 08 06 08 06 08 06 08 06 08 06
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 02 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 03 01 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 04 01 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 05 01 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 06 01 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 07 01 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 08 01 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 09 01 01 01 01 01 01 01
01 01 01 01 01 01 01 01 01 0a 01 01 01 01 01 01
ffffffce 00000032 00000096 000000fa 0000015e 000001c2 00000226 0000028a 000002ee 00000352
f5 06 18 2a 3d 50 63 77 7f 7f
# run 2, saturating gains
03e8 04 7fff 0a
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
fb fb fb fb fb fb fb fb fb fb fb fb fb fb fb fb
fc fc fc fc fc fc fc fc fc fc fc fc fc fc fc fc
fd fd fd fd fd fd fd fd fd fd fd fd fd fd fd fd
fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02
03 03 03 03 03 03 03 03 03 03 03 03 03 03 03 03
04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04
00000000 00000000 00000000 00000000 00000000 00000003 00000000 00000000 00000000 00000000
7f 7f 7f 7f 7f 5f 80 80 80 80

// ==== dv/tb_classifier_head.sv ====
`include "head_defs.svh"

module tb_classifier_head;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAP_N = `HEAD_CH * `HEAD_PIX;
    localparam int WGT_N = `HEAD_OUT * `HEAD_CH;
    localparam int LOAD_CYC = MAP_N + WGT_N + `HEAD_OUT + 100;
    localparam int WATCH_CYC = 16 + 20 + 2 * (`HEAD_OUT * 200 + LOAD_CYC);

    logic clk;
    logic rst_n;
    logic start;
    logic done;
    head_pkg::mul_t cfg_gap_mul;
    head_pkg::shift_t cfg_gap_shift;
    head_pkg::mul_t cfg_fc_mul;
    head_pkg::shift_t cfg_fc_shift;
    logic host_wr_valid;
    logic host_wr_ready;
    head_pkg::addr_t host_wr_addr;
    head_pkg::act_t host_wr_data;
    logic param_wr_en;
    head_pkg::param_sel_t param_wr_sel;
    logic [7:0] param_wr_addr;
    head_pkg::acc_t param_wr_data;
    logic out_valid;
    logic out_ready = 1'b0;
    head_pkg::act_t out_data;
    head_pkg::out_idx_t out_idx;

    int fd;
    logic [31:0] vals [16];
    head_pkg::act_t fmap [MAP_N];
    head_pkg::act_t wgt [WGT_N];
    head_pkg::acc_t bias [`HEAD_OUT];
    head_pkg::act_t exp_score [`HEAD_OUT];
    head_pkg::act_t got_data [$];
    head_pkg::out_idx_t got_idx [$];
    int done_cnt = 0;
    logic [31:0] rng = 32'h0ea07a2a;
    bit stalled = 1'b0;
    head_pkg::act_t held_data;
    head_pkg::out_idx_t held_idx;

    classifier_head i_dut (.*);

    bind classifier_head head_assertions i_assert (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCH_CYC) @(posedge clk);
        $display("Error at %0t: watchdog expired, the scores did not all arrive", $time);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    task automatic end_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic stop_plain(input string msg);
        $display("Error at %0t: %s", $time, msg);
        end_failed();
    endtask

    task automatic check_score(input head_pkg::act_t got, input head_pkg::act_t want,
                               input string what);
        if (got !== want) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, want);
            end_failed();
        end
    endtask

    task automatic check_idx(input head_pkg::out_idx_t got, input head_pkg::out_idx_t want,
                             input string what);
        if (got !== want) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, want);
            end_failed();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // multiply, floor shift, clamp to int8
    function automatic head_pkg::act_t ref_requant(input head_pkg::acc_t acc,
                                                   input head_pkg::mul_t m,
                                                   input head_pkg::shift_t sh);
        longint p;
        p = longint'(acc) * longint'(m);
        p = p >>> sh;
        if (p > 127) return 8'sd127;
        if (p < -128) return -8'sd128;
        return head_pkg::act_t'(p);
    endfunction

    function automatic int hex_val(input byte c);
        if (c >= "0" && c <= "9") return c - "0";
        if (c >= "a" && c <= "f") return c - "a" + 10;
        if (c >= "A" && c <= "F") return c - "A" + 10;
        return -1;
    endfunction

    task automatic get_line(output string s);
        bit found;
        int n;
        found = 1'b0;
        while (!found) begin
            n = $fgets(s, fd);
            if (n == 0) stop_plain("stimulus file ended before all runs were read");
            if (s.len() > 1 && s.getc(0) != "#") found = 1'b1;
        end
    endtask

    task automatic get_values(input int n);
        string s;
        int cnt;
        int h;
        logic [31:0] cur;
        bit in_tok;
        byte c;
        get_line(s);
        cnt = 0;
        cur = '0;
        in_tok = 1'b0;
        for (int k = 0; k <= s.len(); k++) begin
            c = (k < s.len()) ? s.getc(k) : 8'h20;
            h = hex_val(c);
            if (h >= 0) begin
                cur = {cur[27:0], 4'(h)};
                in_tok = 1'b1;
            end else if (in_tok) begin
                if (cnt < 16) vals[cnt] = cur;
                cnt++;
                cur = '0;
                in_tok = 1'b0;
            end
        end
        if (cnt != n) stop_plain("stimulus line has the wrong number of values");
    endtask

    // stream sink with random back-pressure
    always @(posedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                if (!out_valid) stop_plain("out_valid dropped while the score was stalled");
                check_score(out_data, held_data, "stalled score");
                check_idx(out_idx, held_idx, "stalled index");
            end
            stalled = out_valid && !out_ready;
            held_data = out_data;
            held_idx = out_idx;
            if (out_valid && out_ready) begin
                got_data.push_back(out_data);
                got_idx.push_back(out_idx);
            end
            if (done) begin
                done_cnt++;
                if (got_data.size() != `HEAD_OUT) stop_plain("done pulsed before the last score");
            end
            rng = xorshift(rng);
            out_ready <= rng[7];
        end
    end

    task automatic run_test(input int run);
        head_pkg::act_t pooled [`HEAD_CH];
        head_pkg::acc_t acc;
        head_pkg::act_t model;
        head_pkg::mul_t gap_mul;
        head_pkg::shift_t gap_shift;
        head_pkg::mul_t fc_mul;
        head_pkg::shift_t fc_shift;
        get_values(4);
        gap_mul = head_pkg::mul_t'(vals[0]);
        gap_shift = head_pkg::shift_t'(vals[1]);
        fc_mul = head_pkg::mul_t'(vals[2]);
        fc_shift = head_pkg::shift_t'(vals[3]);
        for (int c = 0; c < `HEAD_CH; c++) begin
            get_values(`HEAD_PIX);
            for (int p = 0; p < `HEAD_PIX; p++) fmap[c * `HEAD_PIX + p] = vals[p][7:0];
        end
        @(posedge clk);
        cfg_gap_mul <= gap_mul;
        cfg_gap_shift <= gap_shift;
        cfg_fc_mul <= fc_mul;
        cfg_fc_shift <= fc_shift;
        for (int o = 0; o < `HEAD_OUT; o++) begin
            get_values(`HEAD_CH);
            for (int i = 0; i < `HEAD_CH; i++) wgt[o * `HEAD_CH + i] = vals[i][7:0];
        end
        get_values(`HEAD_OUT);
        for (int o = 0; o < `HEAD_OUT; o++) bias[o] = vals[o];
        get_values(`HEAD_OUT);
        for (int o = 0; o < `HEAD_OUT; o++) exp_score[o] = vals[o][7:0];

        // reference scores from the pool and FC rules
        for (int c = 0; c < `HEAD_CH; c++) begin
            acc = '0;
            for (int p = 0; p < `HEAD_PIX; p++) acc += head_pkg::acc_t'(fmap[c * `HEAD_PIX + p]);
            pooled[c] = ref_requant(acc, gap_mul, gap_shift);
        end
        for (int o = 0; o < `HEAD_OUT; o++) begin
            acc = bias[o];
            for (int i = 0; i < `HEAD_CH; i++) begin
                acc += head_pkg::acc_t'(pooled[i]) * head_pkg::acc_t'(wgt[o * `HEAD_CH + i]);
            end
            model = ref_requant(acc, fc_mul, fc_shift);
            check_score(model, exp_score[o], $sformatf("run %0d reference vs file", run));
        end

        for (int a = 0; a < MAP_N; a++) begin
            host_wr_valid <= 1'b1;
            host_wr_addr <= head_pkg::addr_t'(a);
            host_wr_data <= fmap[a];
            @(posedge clk);
            while (!host_wr_ready) @(posedge clk);
        end
        host_wr_valid <= 1'b0;
        for (int k = 0; k < WGT_N + `HEAD_OUT; k++) begin
            param_wr_en <= 1'b1;
            if (k < WGT_N) begin
                param_wr_sel <= head_pkg::PARAM_WEIGHT;
                param_wr_addr <= 8'(k);
                param_wr_data <= head_pkg::acc_t'(wgt[k]);
            end else begin
                param_wr_sel <= head_pkg::PARAM_BIAS;
                param_wr_addr <= 8'(k - WGT_N);
                param_wr_data <= bias[k - WGT_N];
            end
            @(posedge clk);
        end
        param_wr_en <= 1'b0;

        got_data.delete();
        got_idx.delete();
        done_cnt = 0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (run == 1) begin
            repeat (30) @(posedge clk);
            start <= 1'b1;      // pool engine busy here
            @(posedge clk);
            start <= 1'b0;
        end
        while (done_cnt == 0) @(posedge clk);
        repeat (40) @(posedge clk);

        if (done_cnt != 1) stop_plain("done pulsed more than once in a run");
        if (got_data.size() != `HEAD_OUT) stop_plain("wrong number of scores in a run");
        for (int o = 0; o < `HEAD_OUT; o++) begin
            check_idx(got_idx[o], head_pkg::out_idx_t'(o), $sformatf("run %0d index", run));
            check_score(got_data[o], exp_score[o], $sformatf("run %0d score %0d", run, o));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        cfg_gap_mul = '0;
        cfg_gap_shift = '0;
        cfg_fc_mul = '0;
        cfg_fc_shift = '0;
        host_wr_valid = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        param_wr_en = 1'b0;
        param_wr_sel = head_pkg::PARAM_WEIGHT;
        param_wr_addr = '0;
        param_wr_data = '0;
        fd = $fopen("dv/head_stimulus.txt", "r");
        if (fd == 0) stop_plain("cannot open the stimulus file");
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            if (out_valid || done) stop_plain("output active before any stimulus");
        end
        run_test(1);
        run_test(2);
        $fclose(fd);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== hdl/classifier_head.sv ====
module classifier_head (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  start,
    output logic                  done,

    input  head_pkg::mul_t        cfg_gap_mul,
    input  head_pkg::shift_t      cfg_gap_shift,
    input  head_pkg::mul_t        cfg_fc_mul,
    input  head_pkg::shift_t      cfg_fc_shift,

    input  logic                  host_wr_valid,
    output logic                  host_wr_ready,
    input  head_pkg::addr_t       host_wr_addr,
    input  head_pkg::act_t        host_wr_data,

    input  logic                  param_wr_en,
    input  head_pkg::param_sel_t  param_wr_sel,
    input  logic [7:0]            param_wr_addr,
    input  head_pkg::acc_t        param_wr_data,

    output logic                  out_valid,
    input  logic                  out_ready,
    output head_pkg::act_t        out_data,
    output head_pkg::out_idx_t    out_idx
);

    logic            ram_en;
    logic            ram_we;
    head_pkg::addr_t ram_addr;
    head_pkg::act_t  ram_wdata;
    head_pkg::act_t  ram_rdata;
    logic            pool_done;
    logic            fc_busy;

    fm_bus_if host_bus ();
    fm_bus_if gap_bus ();
    fm_bus_if fc_bus ();

    // host loader only writes
    assign host_bus.req_valid = host_wr_valid;
    assign host_bus.op = head_pkg::BUS_WR;
    assign host_bus.addr = host_wr_addr;
    assign host_bus.wdata = host_wr_data;
    assign host_wr_ready = host_bus.req_ready;

    fm_ram i_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    fm_arbiter i_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .host  (host_bus),
        .gap   (gap_bus),
        .fc    (fc_bus),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    gap_engine i_gap (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .fc_busy   (fc_busy),
        .gap_mul   (cfg_gap_mul),
        .gap_shift (cfg_gap_shift),
        .bus       (gap_bus),
        .pool_done (pool_done)
    );

    fc_engine i_fc (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (pool_done),
        .fc_mul        (cfg_fc_mul),
        .fc_shift      (cfg_fc_shift),
        .param_wr_en   (param_wr_en),
        .param_wr_sel  (param_wr_sel),
        .param_wr_addr (param_wr_addr),
        .param_wr_data (param_wr_data),
        .bus           (fc_bus),
        .busy          (fc_busy),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_idx       (out_idx),
        .done          (done)
    );

endmodule

// ==== hdl/fc_engine.sv ====
`include "head_defs.svh"

module fc_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  head_pkg::mul_t        fc_mul,
    input  head_pkg::shift_t      fc_shift,
    input  logic                  param_wr_en,
    input  head_pkg::param_sel_t  param_wr_sel,
    input  logic [7:0]            param_wr_addr,
    input  head_pkg::acc_t        param_wr_data,
    fm_bus_if.requester           bus,
    output logic                  busy,
    output logic                  out_valid,
    input  logic                  out_ready,
    output head_pkg::act_t        out_data,
    output head_pkg::out_idx_t    out_idx,
    output logic                  done
);

    localparam int CH_W = $clog2(`HEAD_CH);
    localparam int N_WGT = `HEAD_OUT * `HEAD_CH;
    localparam logic [CH_W:0] CH_CNT = `HEAD_CH;

    head_pkg::fc_state_t state;
    head_pkg::act_t      weights [N_WGT];     // out * HEAD_CH + in
    head_pkg::acc_t      biases [`HEAD_OUT];
    head_pkg::act_t      vec [`HEAD_CH];      // local copy of pooled vector
    logic [CH_W:0]       icnt;
    logic [CH_W:0]       rcnt;
    logic [CH_W-1:0]     in_cnt;
    head_pkg::out_idx_t  out_cnt;
    head_pkg::acc_t      acc;
    head_pkg::acc_t      mac_sum;
    logic [7:0]          w_idx;

    always_ff @(posedge clk) begin
        if (param_wr_en) begin
            if (param_wr_sel == head_pkg::PARAM_WEIGHT && param_wr_addr < 8'(N_WGT)) begin
                weights[param_wr_addr] <= param_wr_data[`HEAD_DATA_W-1:0];
            end else if (param_wr_sel == head_pkg::PARAM_BIAS
                         && param_wr_addr < 8'(`HEAD_OUT)) begin
                biases[param_wr_addr[3:0]] <= param_wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rvalid) begin
            vec[rcnt[CH_W-1:0]] <= bus.rdata;
        end
    end

    assign w_idx = 8'(out_cnt) * 8'(`HEAD_CH) + 8'(in_cnt);
    assign mac_sum = acc + head_pkg::acc_t'(vec[in_cnt]) * head_pkg::acc_t'(weights[w_idx]);

    assign bus.req_valid = (state == head_pkg::FC_FETCH) && (icnt < CH_CNT);
    assign bus.op = head_pkg::BUS_RD;
    assign bus.addr = head_pkg::addr_t'(`HEAD_POOL_BASE + icnt);
    assign bus.wdata = '0;        // read only

    assign busy = (state != head_pkg::FC_IDLE);
    assign out_idx = out_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= head_pkg::FC_IDLE;
            icnt <= '0;
            rcnt <= '0;
            in_cnt <= '0;
            out_cnt <= '0;
            acc <= '0;
            out_data <= '0;
            out_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                head_pkg::FC_IDLE: begin
                    if (start) begin
                        icnt <= '0;
                        rcnt <= '0;
                        state <= head_pkg::FC_FETCH;
                    end
                end
                head_pkg::FC_FETCH: begin
                    if (bus.req_valid && bus.req_ready) begin
                        icnt <= icnt + 1'b1;
                    end
                    if (bus.rvalid) begin
                        rcnt <= rcnt + 1'b1;
                    end
                    if (rcnt == CH_CNT) begin
                        out_cnt <= '0;
                        in_cnt <= '0;
                        acc <= biases[0];
                        state <= head_pkg::FC_MAC;
                    end
                end
                head_pkg::FC_MAC: begin
                    acc <= mac_sum;
                    in_cnt <= in_cnt + 1'b1;
                    if (in_cnt == CH_W'(`HEAD_CH - 1)) begin
                        out_data <= head_pkg::requant(mac_sum, fc_mul, fc_shift);
                        out_valid <= 1'b1;
                        state <= head_pkg::FC_EMIT;
                    end
                end
                default: begin
                    if (out_ready) begin      // stalls here under back-pressure
                        out_valid <= 1'b0;
                        in_cnt <= '0;
                        if (out_cnt == head_pkg::out_idx_t'(`HEAD_OUT - 1)) begin
                            done <= 1'b1;
                            state <= head_pkg::FC_IDLE;
                        end else begin
                            out_cnt <= out_cnt + 1'b1;
                            acc <= biases[out_cnt + 1'b1];
                            state <= head_pkg::FC_MAC;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/fm_arbiter.sv ====
module fm_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    fm_bus_if.arbiter        host,
    fm_bus_if.arbiter        gap,
    fm_bus_if.arbiter        fc,
    output logic             en,
    output logic             we,
    output head_pkg::addr_t  addr,
    output head_pkg::act_t   wdata,
    input  head_pkg::act_t   rdata
);

    logic [2:0]        valid;
    logic [2:0]        grant;
    logic [1:0]        ptr;          // requester with top priority
    logic [1:0]        win;
    head_pkg::bus_op_t win_op;
    logic              rd_pend;
    logic [1:0]        rd_owner;

    assign valid = {fc.req_valid, gap.req_valid, host.req_valid};

    always_comb begin
        int idx;
        grant = '0;
        win = '0;
        for (int k = 0; k < 3; k++) begin
            idx = (int'(ptr) + k) % 3;
            if (valid[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                win = 2'(idx);
            end
        end
    end

    always_comb begin
        case (win)
            2'd1: begin
                win_op = gap.op;
                addr = gap.addr;
                wdata = gap.wdata;
            end
            2'd2: begin
                win_op = fc.op;
                addr = fc.addr;
                wdata = fc.wdata;
            end
            default: begin
                win_op = host.op;
                addr = host.addr;
                wdata = host.wdata;
            end
        endcase
    end

    assign en = |grant;
    assign we = en && (win_op == head_pkg::BUS_WR);

    assign host.req_ready = grant[0];
    assign gap.req_ready = grant[1];
    assign fc.req_ready = grant[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
            rd_pend <= 1'b0;
            rd_owner <= '0;
        end else begin
            rd_pend <= en && !we;
            if (en) begin
                rd_owner <= win;
                ptr <= (win == 2'd2) ? 2'd0 : win + 2'd1;   // rotate past winner
            end
        end
    end

    // route returning read data to whoever issued it
    assign host.rvalid = rd_pend && (rd_owner == 2'd0);
    assign gap.rvalid = rd_pend && (rd_owner == 2'd1);
    assign fc.rvalid = rd_pend && (rd_owner == 2'd2);

    assign host.rdata = rdata;
    assign gap.rdata = rdata;
    assign fc.rdata = rdata;

endmodule

// ==== hdl/fm_bus_if.sv ====
interface fm_bus_if;

    logic               req_valid;
    logic               req_ready;
    head_pkg::bus_op_t  op;
    head_pkg::addr_t    addr;
    head_pkg::act_t     wdata;
    logic               rvalid;       // one cycle after a read transfers
    head_pkg::act_t     rdata;

    modport requester (
        output req_valid,
        output op,
        output addr,
        output wdata,
        input  req_ready,
        input  rvalid,
        input  rdata
    );

    modport arbiter (
        input  req_valid,
        input  op,
        input  addr,
        input  wdata,
        output req_ready,
        output rvalid,
        output rdata
    );

endinterface

// ==== hdl/fm_ram.sv ====
`include "head_defs.svh"

module fm_ram (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            we,
    input  head_pkg::addr_t addr,
    input  head_pkg::act_t  wdata,
    output head_pkg::act_t  rdata
);

    localparam int DEPTH = 2 ** `HEAD_ADDR_W;

    head_pkg::act_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // read port, holds last word between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== hdl/gap_engine.sv ====
`include "head_defs.svh"

module gap_engine (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              fc_busy,
    input  head_pkg::mul_t    gap_mul,
    input  head_pkg::shift_t  gap_shift,
    fm_bus_if.requester       bus,
    output logic              pool_done
);

    localparam int CH_W = $clog2(`HEAD_CH);
    localparam int PIX_W = $clog2(`HEAD_PIX);
    localparam logic [PIX_W:0] PIX_CNT = `HEAD_PIX;

    head_pkg::gap_state_t state;
    logic [CH_W-1:0]      ch;
    logic [PIX_W-1:0]     pix;
    logic [PIX_W:0]       rcnt;         // returned reads this channel
    head_pkg::acc_t       sum;
    head_pkg::act_t       pooled;
    head_pkg::addr_t      rd_addr;
    head_pkg::addr_t      wr_addr;
    logic                 xfer;

    assign rd_addr = head_pkg::addr_t'(ch * `HEAD_PIX + pix);
    assign wr_addr = head_pkg::addr_t'(`HEAD_POOL_BASE + ch);
    assign xfer = bus.req_valid && bus.req_ready;

    assign bus.req_valid = (state == head_pkg::GAP_ISSUE) || (state == head_pkg::GAP_WRITE);
    assign bus.op = (state == head_pkg::GAP_WRITE) ? head_pkg::BUS_WR : head_pkg::BUS_RD;
    assign bus.addr = (state == head_pkg::GAP_WRITE) ? wr_addr : rd_addr;
    assign bus.wdata = pooled;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= head_pkg::GAP_IDLE;
            ch <= '0;
            pix <= '0;
            rcnt <= '0;
            sum <= '0;
            pooled <= '0;
            pool_done <= 1'b0;
        end else begin
            pool_done <= 1'b0;
            if (bus.rvalid) begin
                sum <= sum + head_pkg::acc_t'(bus.rdata);   // sign extended
                rcnt <= rcnt + 1'b1;
            end
            case (state)
                head_pkg::GAP_IDLE: begin
                    if (start && !fc_busy && !pool_done) begin
                        ch <= '0;
                        pix <= '0;
                        rcnt <= '0;
                        sum <= '0;
                        state <= head_pkg::GAP_ISSUE;
                    end
                end
                head_pkg::GAP_ISSUE: begin
                    if (xfer) begin
                        pix <= pix + 1'b1;
                        if (pix == PIX_W'(`HEAD_PIX - 1)) begin
                            state <= head_pkg::GAP_DRAIN;
                        end
                    end
                end
                head_pkg::GAP_DRAIN: begin
                    if (rcnt == PIX_CNT) begin
                        pooled <= head_pkg::requant(sum, gap_mul, gap_shift);
                        state <= head_pkg::GAP_WRITE;
                    end
                end
                default: begin
                    if (xfer) begin
                        sum <= '0;
                        rcnt <= '0;
                        pix <= '0;
                        if (ch == CH_W'(`HEAD_CH - 1)) begin
                            pool_done <= 1'b1;     // last pooled byte granted
                            state <= head_pkg::GAP_IDLE;
                        end else begin
                            ch <= ch + 1'b1;
                            state <= head_pkg::GAP_ISSUE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/head_defs.svh ====
`ifndef HEAD_DEFS_SVH
`define HEAD_DEFS_SVH

`define HEAD_CH        16     // feature channels
`define HEAD_PIX       16     // pixels per channel
`define HEAD_OUT       10     // class scores

`define HEAD_DATA_W    8
`define HEAD_ACC_W     32
`define HEAD_MUL_W     16
`define HEAD_SHIFT_W   6

`define HEAD_ADDR_W    10
`define HEAD_POOL_BASE 256    // pooled vector, one byte per channel

`endif

// ==== hdl/head_pkg.sv ====
`include "head_defs.svh"

package head_pkg;

    typedef logic signed [`HEAD_DATA_W-1:0]  act_t;
    typedef logic signed [`HEAD_ACC_W-1:0]   acc_t;
    typedef logic signed [`HEAD_MUL_W-1:0]   mul_t;
    typedef logic        [`HEAD_SHIFT_W-1:0] shift_t;
    typedef logic        [`HEAD_ADDR_W-1:0]  addr_t;
    typedef logic        [3:0]               out_idx_t;

    typedef enum logic {BUS_RD, BUS_WR} bus_op_t;
    typedef enum logic {PARAM_WEIGHT, PARAM_BIAS} param_sel_t;

    typedef enum logic [1:0] {GAP_IDLE, GAP_ISSUE, GAP_DRAIN, GAP_WRITE} gap_state_t;
    typedef enum logic [1:0] {FC_IDLE, FC_FETCH, FC_MAC, FC_EMIT} fc_state_t;

    localparam int ACT_MAX = 2 ** (`HEAD_DATA_W - 1) - 1;
    localparam int ACT_MIN = -ACT_MAX - 1;

    // multiply, arithmetic shift, saturate; truncating, no rounding
    function automatic act_t requant(acc_t acc, mul_t mul, shift_t shift);
        logic signed [`HEAD_ACC_W+`HEAD_MUL_W-1:0] prod;
        logic signed [`HEAD_ACC_W+`HEAD_MUL_W-1:0] scaled;
        prod = acc * mul;
        scaled = prod >>> shift;
        if (scaled > ACT_MAX) begin
            return act_t'(ACT_MAX);
        end
        if (scaled < ACT_MIN) begin
            return act_t'(ACT_MIN);
        end
        return act_t'(scaled);
    endfunction

endpackage

// ==== list.f ====
+incdir+hdl
hdl/head_pkg.sv
hdl/fm_bus_if.sv
hdl/fm_ram.sv
hdl/fm_arbiter.sv
hdl/gap_engine.sv
hdl/fc_engine.sv
hdl/classifier_head.sv
dv/head_assertions.sv
dv/tb_classifier_head.sv

// ==== run.sh ====
#!/bin/sh
# build and run the classifier head testbench, pass only on the pass line
verilator --binary --timing -Wno-fatal -f list.f \
    --top-module tb_classifier_head -o sim_head \
    && ./obj_dir/sim_head | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }
